// ==== bench/gb_soc_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module gb_soc_properties (
  input logic              clk,
  input logic              reset,
  input gb_pkg::t_phase_t  t_phase,
  input logic              halted,
  input logic              mmu_req_read,
  input logic              mmu_req_write,
  input logic              core_drive
);

  import gb_pkg::*;

  int fail_count = 0;  // Sampled by the testbench at the end of the run

  function automatic t_phase_t phase_after(t_phase_t p);
    case (p)
      T1:      return T2;
      T2:      return T3;
      T3:      return T4;
      default: return T1;
    endcase
  endfunction

  // Phase walks T1..T4 and wraps, unless the core has stopped
  phase_order: assert property (@(posedge clk) disable iff (reset)
    !halted |=> t_phase == phase_after($past(t_phase)))
  else begin
    $error("T-phase did not advance in order");
    fail_count++;
  end

  strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(mmu_req_read && mmu_req_write))
  else begin
    $error("read and write strobes high together");
    fail_count++;
  end

  strobes_low_t1: assert property (@(posedge clk) disable iff (reset)
    (t_phase == T1) |-> (!mmu_req_read && !mmu_req_write))
  else begin
    $error("bus strobe high during T1");
    fail_count++;
  end

  // The MMU owns the data bus for the whole read strobe
  no_drive_on_read: assert property (@(posedge clk) disable iff (reset)
    mmu_req_read |-> !core_drive)
  else begin
    $error("core drives data_bus during a read");
    fail_count++;
  end

endmodule

`default_nettype wire

// ==== bench/gb_soc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module gb_soc_tb;

  localparam int TIMEOUT_CYCLES = 4000;
  localparam int RESET_CYCLES   = 5;

  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  data;
  } write_rec_t;

  logic        clk;
  logic        reset;
  logic        load_en;
  logic [15:0] load_addr;
  logic [7:0]  load_data;
  logic [15:0] bus_addr;
  logic        bus_write;
  logic [7:0]  bus_wdata;
  logic        halted;

  logic [7:0]  prog_bytes[$];   // Image loaded from address 0000
  write_rec_t  pokes[$];        // Extra data bytes for the loader
  write_rec_t  exp_writes[$];
  write_rec_t  got_writes[$];
  logic        write_seen = 1'b0;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          prop_fails;

  gb_soc #(
    .ADDR_WIDTH (16)
  ) u_dut (
    .clk       (clk),
    .reset     (reset),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .bus_addr  (bus_addr),
    .bus_write (bus_write),
    .bus_wdata (bus_wdata),
    .halted    (halted)
  );

  bind cpu_core gb_soc_properties u_props (
    .clk           (clk),
    .reset         (reset),
    .t_phase       (t_phase),
    .halted        (halted),
    .mmu_req_read  (mmu_req_read),
    .mmu_req_write (mmu_req_write),
    .core_drive    (mmu_req_write)  // Core enables its bus driver with the write strobe
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // One entry per rise of the write strobe sampled mid-cycle
  always @(negedge clk) begin
    if (!reset && bus_write && !write_seen) got_writes.push_back({bus_addr, bus_wdata});
    write_seen = bus_write;
  end

  function automatic logic [7:0] rand_byte();
    return 8'($urandom());
  endfunction

  // Reference results for ADD, SUB, AND, XOR, OR in that order
  function automatic logic [7:0] alu_expect(int k, logic [7:0] a, logic [7:0] b);
    case (k)
      0:       return a + b;
      1:       return a - b;
      2:       return a & b;
      3:       return a ^ b;
      default: return a | b;
    endcase
  endfunction

  task automatic clear_lists();
    prog_bytes.delete();
    pokes.delete();
    exp_writes.delete();
  endtask

  task automatic expect_write(input logic [15:0] addr, input logic [7:0] data);
    exp_writes.push_back({addr, data});
  endtask

  task automatic load_image();
    foreach (prog_bytes[i]) begin
      @(posedge clk);
      #1;
      load_en   = 1'b1;
      load_addr = 16'(i);
      load_data = prog_bytes[i];
    end
    foreach (pokes[i]) begin
      @(posedge clk);
      #1;
      load_en   = 1'b1;
      load_addr = pokes[i].addr;
      load_data = pokes[i].data;
    end
    @(posedge clk);
    #1;
    load_en = 1'b0;
  endtask

  task automatic run_program(output bit finished);
    int cycles;
    @(posedge clk);
    #1;
    reset = 1'b1;
    got_writes.delete();
    repeat (RESET_CYCLES) @(posedge clk);
    load_image();  // Memory only accepts the loader while in reset
    @(posedge clk);
    #1;
    reset  = 1'b0;
    cycles = 0;
    while (!halted && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    finished = halted;
  endtask

  task automatic run_and_check(input string name);
    bit finished;
    int errs_before;
    int n;
    errs_before = errors;
    run_program(finished);
    if (!finished) begin
      $display("Timeout: the CPU did not halt within %0d cycles in %s", TIMEOUT_CYCLES, name);
      errors++;
    end
    assert (got_writes.size() == exp_writes.size()) else begin
      $display("[FAIL] bus_write count exp=%0h got=%0h", exp_writes.size(), got_writes.size());
      errors++;
    end
    n = (got_writes.size() < exp_writes.size()) ? got_writes.size() : exp_writes.size();
    for (int i = 0; i < n; i++) begin
      assert (got_writes[i].addr == exp_writes[i].addr) else begin
        $display("[FAIL] bus_addr exp=%h got=%h", exp_writes[i].addr, got_writes[i].addr);
        errors++;
      end
      assert (got_writes[i].data == exp_writes[i].data) else begin
        $display("[FAIL] bus_wdata exp=%h got=%h", exp_writes[i].data, got_writes[i].data);
        errors++;
      end
    end
    tests_run++;
    if (errors != errs_before) tests_failed++;
    $display("%s: %s, %0d writes", name, (errors == errs_before) ? "ok" : "FAILED",
             got_writes.size());
  endtask

  task automatic load_and_store();
    logic [7:0] value;
    logic [7:0] hi;
    logic [7:0] lo;
    clear_lists();
    value = rand_byte();
    hi    = 8'h80 | rand_byte();  // Stay clear of the program image
    lo    = rand_byte();
    prog_bytes = '{8'h3E, value, 8'h26, hi, 8'h2E, lo, 8'h77, 8'h76};
    expect_write({hi, lo}, value);
    run_and_check("load_store");
  endtask

  task automatic alu_ops();
    logic [7:0] opcodes [5];
    logic [7:0] a;
    logic [7:0] b;
    clear_lists();
    opcodes = '{8'h80, 8'h90, 8'hA0, 8'hA8, 8'hB0};  // op A,B
    prog_bytes.push_back(8'h26);
    prog_bytes.push_back(8'hC1);
    for (int k = 0; k < 5; k++) begin
      a = rand_byte();
      b = rand_byte();
      prog_bytes.push_back(8'h2E);
      prog_bytes.push_back(8'(k));
      prog_bytes.push_back(8'h3E);
      prog_bytes.push_back(a);
      prog_bytes.push_back(8'h06);
      prog_bytes.push_back(b);
      prog_bytes.push_back(opcodes[k]);
      prog_bytes.push_back(8'h77);
      expect_write({8'hC1, 8'(k)}, alu_expect(k, a, b));
    end
    prog_bytes.push_back(8'h76);
    run_and_check("alu_ops");
  endtask

  task automatic inc_dec_readback(input string name, input logic [7:0] mem_val,
                                  input logic [7:0] b_val);
    clear_lists();
    pokes.push_back({16'hD040, mem_val});
    prog_bytes = '{
      8'h26, 8'hD0, 8'h2E, 8'h40,  // HL = D040
      8'h06, b_val,
      8'h7E, 8'h3C, 8'h05,         // LD A,(HL)  INC A  DEC B
      8'h2E, 8'h41, 8'h77,
      8'h3E, 8'h00, 8'hB0,         // A = 0 | B
      8'h2E, 8'h42, 8'h77,
      8'h76
    };
    expect_write(16'hD041, mem_val + 8'd1);
    expect_write(16'hD042, b_val - 8'd1);
    run_and_check(name);
  endtask

  task automatic jump_paths();
    logic [7:0] image [44];
    clear_lists();
    image = '{
      8'h26, 8'hC0, 8'h2E, 8'h00,  // 00 HL = C000
      8'h3E, 8'h11,                // 04
      8'hC3, 8'h0B, 8'h00,         // 06 JP 000B
      8'h77, 8'h76,                // 09 skipped
      8'h77,                       // 0B
      8'h06, 8'h11, 8'h90,         // 0C A - B gives zero
      8'hCA, 8'h14, 8'h00,         // 0F JP Z taken
      8'h77, 8'h76,                // 12 skipped
      8'hC2, 8'h19, 8'h00,         // 14 JP NZ not taken
      8'h3E, 8'h33, 8'h77,         // 17
      8'h06, 8'h01, 8'h90,         // 1A A - B gives 32
      8'hCA, 8'h22, 8'h00,         // 1D JP Z not taken
      8'h2E, 8'h01, 8'h77,         // 20
      8'hC2, 8'h28, 8'h00,         // 23 JP NZ taken
      8'h77, 8'h76,                // 26 skipped
      8'h3E, 8'h44, 8'h77, 8'h76   // 28
    };
    foreach (image[i]) prog_bytes.push_back(image[i]);
    expect_write(16'hC000, 8'h11);
    expect_write(16'hC000, 8'h33);
    expect_write(16'hC001, 8'h32);
    expect_write(16'hC001, 8'h44);
    run_and_check("jumps");
  endtask

  task automatic push_pairs();
    logic [7:0] b;
    logic [7:0] c;
    logic [7:0] d;
    logic [7:0] e;
    clear_lists();
    b = rand_byte();
    c = rand_byte();
    d = rand_byte();
    e = rand_byte();
    prog_bytes = '{8'h06, b, 8'h0E, c, 8'h16, d, 8'h1E, e, 8'hC5, 8'hD5, 8'h76};
    // Stack grows down from FFFE with the high byte first
    expect_write(16'hFFFD, b);
    expect_write(16'hFFFC, c);
    expect_write(16'hFFFB, d);
    expect_write(16'hFFFA, e);
    run_and_check("push");
  endtask

  initial begin
    reset     = 1'b1;
    load_en   = 1'b0;
    load_addr = 16'h0000;
    load_data = 8'h00;
    void'($urandom(32'h5899));
    load_and_store();
    alu_ops();
    inc_dec_readback("inc_dec_rand", rand_byte(), rand_byte());
    inc_dec_readback("inc_dec_wrap", 8'hFF, 8'h00);
    jump_paths();
    push_pairs();
    prop_fails = u_dut.u_core.u_props.fail_count;
    if (prop_fails != 0) begin
      $display("Bound bus and phase assertions failed %0d times", prop_fails);
      errors += prop_fails;
    end
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== gb_soc.f ====
logic/gb_pkg.sv
logic/cpu_decode.sv
logic/cpu_alu.sv
logic/cpu_core.sv
logic/mmu.sv
logic/gb_soc.sv
bench/gb_soc_properties.sv
bench/gb_soc_tb.sv

// ==== logic/cpu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_alu (
  input  gb_pkg::alu_op_t alu_op,
  input  logic [7:0]      operand_a,
  input  logic [7:0]      operand_b,
  input  logic [7:0]      flags_in,
  output logic [7:0]      result,
  output logic [7:0]      flags_out
);

  import gb_pkg::*;

  logic       is_sub;
  logic [8:0] wide;   // Byte result with carry out
  logic [4:0] half;   // Low nibble result with carry out

  assign is_sub = (alu_op == ALU_SUB);
  assign wide   = is_sub ? {1'b0, operand_a} - {1'b0, operand_b}
                         : {1'b0, operand_a} + {1'b0, operand_b};
  assign half   = is_sub ? {1'b0, operand_a[3:0]} - {1'b0, operand_b[3:0]}
                         : {1'b0, operand_a[3:0]} + {1'b0, operand_b[3:0]};

  always_comb begin
    result    = operand_a;
    flags_out = flags_in;
    case (alu_op)
      ALU_ADD, ALU_SUB: begin
        result            = wide[7:0];
        flags_out[FLAG_N] = is_sub;
        flags_out[FLAG_H] = half[4];  // Borrow on SUB
        flags_out[FLAG_C] = wide[8];
      end
      ALU_AND: begin
        result            = operand_a & operand_b;
        flags_out[FLAG_N] = 1'b0;
        flags_out[FLAG_H] = 1'b1;
        flags_out[FLAG_C] = 1'b0;
      end
      ALU_XOR, ALU_OR: begin
        result            = (alu_op == ALU_XOR) ? operand_a ^ operand_b
                                                : operand_a | operand_b;
        flags_out[FLAG_N] = 1'b0;
        flags_out[FLAG_H] = 1'b0;
        flags_out[FLAG_C] = 1'b0;
      end
      ALU_INC: begin
        result            = operand_a + 8'd1;
        flags_out[FLAG_N] = 1'b0;
        flags_out[FLAG_H] = (operand_a[3:0] == 4'hF);
      end
      ALU_DEC: begin
        result            = operand_a - 8'd1;
        flags_out[FLAG_N] = 1'b1;
        flags_out[FLAG_H] = (operand_a[3:0] == 4'h0);
      end
      ALU_MOV: result = operand_b;  // Flags pass through
      default: ;
    endcase
    if (alu_op != ALU_NONE && alu_op != ALU_MOV) flags_out[FLAG_Z] = (result == 8'h00);
  end

endmodule

`default_nettype wire

// ==== logic/cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
  input  logic        clk,
  input  logic        reset,
  output logic [15:0] addr_bus,
  inout  wire  [7:0]  data_bus,
  output logic        mmu_req_read,
  output logic        mmu_req_write,
  output logic        halted
);

  import gb_pkg::*;

  cpu_regs_t     regs;
  cpu_regs_t     regs_t4;       // Register file after this cycle's IDU and ALU work
  t_phase_t      t_phase;
  cycle_count_t  cycle_count;
  cycle_count_t  next_count;
  cycle_word_t   cw;            // Word of the machine cycle in progress
  control_word_t control_word;
  logic [7:0]    opcode;
  logic [7:0]    wdata;
  logic [7:0]    alu_a;
  logic [7:0]    alu_b;
  logic [7:0]    alu_result;
  logic [7:0]    alu_flags;
  logic          cond_met;

  function automatic logic [15:0] idu(logic [15:0] val, idu_op_t op);
    case (op)
      IDU_INC: return val + 16'd1;
      IDU_DEC: return val - 16'd1;
      default: return val;
    endcase
  endfunction

  cpu_decode u_decode (
    .opcode       (opcode),
    .control_word (control_word)
  );

  cpu_alu u_alu (
    .alu_op    (cw.alu_op),
    .operand_a (alu_a),
    .operand_b (alu_b),
    .flags_in  (regs.flags),
    .result    (alu_result),
    .flags_out (alu_flags)
  );

  // Bus is released unless a write strobe is out
  assign data_bus = mmu_req_write ? wdata : 'z;

  assign alu_a = get_reg(regs, cw.alu_dst);
  assign alu_b = get_reg(regs, cw.alu_src);

  always_comb begin
    case (cw.cond)
      COND_NZ: cond_met = !regs.flags[FLAG_Z];
      COND_Z:  cond_met = regs.flags[FLAG_Z];
      COND_NC: cond_met = !regs.flags[FLAG_C];
      default: cond_met = regs.flags[FLAG_C];
    endcase
  end

  // Opcode is already latched in the fetch cycle, so num_cycles is the next instruction's
  always_comb begin
    if (cw.misc_op == MISC_COND_CHECK && !cond_met) begin
      next_count = FINAL_SLOT;
    end else if (cycle_count == FINAL_SLOT) begin
      next_count = (control_word.num_cycles == 3'd1) ? FINAL_SLOT : cycle_count_t'(0);
    end else if (cycle_count + 3'd1 >= control_word.num_cycles - 3'd1) begin
      next_count = FINAL_SLOT;
    end else begin
      next_count = cycle_count + 3'd1;
    end
  end

  always_comb begin
    regs_t4 = regs;
    case (cw.addr_src)
      ADDR_PC: regs_t4.pc = idu(regs.pc, cw.idu_op);
      ADDR_SP: regs_t4.sp = idu(regs.sp, cw.idu_op);
      ADDR_HL: {regs_t4.h, regs_t4.l} = idu({regs.h, regs.l}, cw.idu_op);
      ADDR_WZ: {regs_t4.w, regs_t4.z} = idu({regs.w, regs.z}, cw.idu_op);
      default: ;
    endcase
    if (cw.alu_op != ALU_NONE) begin
      regs_t4       = set_reg(regs_t4, cw.alu_dst, alu_result);
      regs_t4.flags = alu_flags;
    end
    if (cw.misc_op == MISC_JUMP_WZ) regs_t4.pc = {regs.w, regs.z};
  end

  always_ff @(posedge clk) begin
    if (t_phase == T2 && cw.data_bus_op == DATA_BUS_OP_WRITE) begin
      wdata <= get_reg(regs, cw.data_bus_src);
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regs          <= '{pc: 16'h0000, sp: 16'hFFFE, default: '0};
      t_phase       <= T1;
      cycle_count   <= FINAL_SLOT;
      cw            <= FETCH_CYCLE;
      opcode        <= 8'h00;           // NOP, so the first cycle is a fetch
      addr_bus      <= 16'h0000;
      mmu_req_read  <= 1'b0;
      mmu_req_write <= 1'b0;
      halted        <= 1'b0;
    end else if (!halted) begin
      case (t_phase)
        T1: begin
          case (cw.addr_src)
            ADDR_PC: addr_bus <= regs.pc;
            ADDR_SP: addr_bus <= regs.sp;
            ADDR_HL: addr_bus <= {regs.h, regs.l};
            ADDR_WZ: addr_bus <= {regs.w, regs.z};
            default: ;  // Address holds
          endcase
          t_phase <= T2;
        end
        T2: begin
          mmu_req_read  <= (cw.data_bus_op == DATA_BUS_OP_READ);
          mmu_req_write <= (cw.data_bus_op == DATA_BUS_OP_WRITE);
          t_phase       <= T3;
        end
        T3: begin
          if (cw.data_bus_op == DATA_BUS_OP_READ) begin
            if (cycle_count == FINAL_SLOT) opcode <= data_bus;
            else regs <= set_reg(regs, cw.data_bus_src, data_bus);
          end
          t_phase <= T4;
        end
        default: begin  // T4
          mmu_req_read  <= 1'b0;
          mmu_req_write <= 1'b0;
          t_phase       <= T1;
          if (cw.misc_op == MISC_HALT) begin
            halted <= 1'b1;
          end else begin
            regs        <= regs_t4;
            cycle_count <= next_count;
            cw          <= control_word.cycles[next_count];
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/cpu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_decode (
  input  logic [7:0]             opcode,
  output gb_pkg::control_word_t  control_word
);

  import gb_pkg::*;

  reg_sel_t dst_reg;   // Register in opcode bits 5:3
  reg_sel_t src_reg;   // Register in opcode bits 2:0
  reg_sel_t push_hi;
  reg_sel_t push_lo;
  alu_op_t  alu_kind;

  // 3-bit register field, index 6 is (HL) and not a plain register
  function automatic reg_sel_t reg_of(logic [2:0] idx);
    case (idx)
      3'd0:    return REG_B;
      3'd1:    return REG_C;
      3'd2:    return REG_D;
      3'd3:    return REG_E;
      3'd4:    return REG_H;
      3'd5:    return REG_L;
      3'd7:    return REG_A;
      default: return REG_NONE;
    endcase
  endfunction

  function automatic alu_op_t alu_of(logic [2:0] sel);
    case (sel)
      3'd0:    return ALU_ADD;
      3'd2:    return ALU_SUB;
      3'd4:    return ALU_AND;
      3'd5:    return ALU_XOR;
      3'd6:    return ALU_OR;
      default: return ALU_NONE;  // ADC, SBC, CP not supported
    endcase
  endfunction

  function automatic cycle_word_t bus_word(addr_src_t src, data_bus_op_t op, reg_sel_t r,
                                           idu_op_t idu);
    cycle_word_t word;
    word              = IDLE_CYCLE;
    word.addr_src     = src;
    word.data_bus_op  = op;
    word.data_bus_src = r;
    word.idu_op       = idu;
    return word;
  endfunction

  assign dst_reg  = reg_of(opcode[5:3]);
  assign src_reg  = reg_of(opcode[2:0]);
  assign push_hi  = reg_of({opcode[5:4], 1'b0});
  assign push_lo  = reg_of({opcode[5:4], 1'b1});
  assign alu_kind = alu_of(opcode[5:3]);

  always_comb begin
    control_word.num_cycles = 3'd1;
    for (int i = 0; i < MAX_CYCLES_PER_INSTR; i++) begin
      control_word.cycles[i] = IDLE_CYCLE;
    end
    control_word.cycles[FINAL_SLOT] = FETCH_CYCLE;

    casez (opcode)
      8'h76: control_word.cycles[FINAL_SLOT] = HALT_CYCLE;
      8'h77: begin  // LD (HL),A
        control_word.num_cycles = 3'd2;
        control_word.cycles[0]  = bus_word(ADDR_HL, DATA_BUS_OP_WRITE, REG_A, IDU_NONE);
      end
      8'h7E: begin  // LD A,(HL)
        control_word.num_cycles = 3'd2;
        control_word.cycles[0]  = bus_word(ADDR_HL, DATA_BUS_OP_READ, REG_A, IDU_NONE);
      end
      8'b00???110: begin  // LD r,n8
        if (dst_reg != REG_NONE) begin
          control_word.num_cycles = 3'd2;
          control_word.cycles[0]  = bus_word(ADDR_PC, DATA_BUS_OP_READ, dst_reg, IDU_INC);
        end
      end
      8'b00???10?: begin  // INC r and DEC r, done alongside the fetch
        if (dst_reg != REG_NONE) begin
          control_word.cycles[FINAL_SLOT].alu_op  = opcode[0] ? ALU_DEC : ALU_INC;
          control_word.cycles[FINAL_SLOT].alu_dst = dst_reg;
          control_word.cycles[FINAL_SLOT].alu_src = dst_reg;
        end
      end
      8'b10??????: begin
        if (src_reg != REG_NONE && alu_kind != ALU_NONE) begin
          control_word.cycles[FINAL_SLOT].alu_op  = alu_kind;
          control_word.cycles[FINAL_SLOT].alu_dst = REG_A;
          control_word.cycles[FINAL_SLOT].alu_src = src_reg;
        end
      end
      8'hC3, 8'hC2, 8'hCA, 8'hD2, 8'hDA: begin
        control_word.num_cycles = 3'd4;
        control_word.cycles[0]  = bus_word(ADDR_PC, DATA_BUS_OP_READ, REG_Z, IDU_INC);
        control_word.cycles[1]  = bus_word(ADDR_PC, DATA_BUS_OP_READ, REG_W, IDU_INC);
        control_word.cycles[2].misc_op = MISC_JUMP_WZ;
        if (opcode != 8'hC3) begin
          // Not taken ends after the second operand byte
          control_word.cycles[1].misc_op = MISC_COND_CHECK;
          control_word.cycles[1].cond    = cond_t'(opcode[4:3]);
        end
      end
      8'hC5, 8'hD5, 8'hE5: begin  // PUSH, high byte first
        control_word.num_cycles = 3'd4;
        control_word.cycles[0]  = bus_word(ADDR_SP, DATA_BUS_OP_ALU_ONLY, REG_NONE, IDU_DEC);
        control_word.cycles[1]  = bus_word(ADDR_SP, DATA_BUS_OP_WRITE, push_hi, IDU_DEC);
        control_word.cycles[2]  = bus_word(ADDR_SP, DATA_BUS_OP_WRITE, push_lo, IDU_NONE);
      end
      default: ;  // Unknown opcodes run as NOP
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/gb_pkg.sv ====
`default_nettype none

package gb_pkg;

  localparam int MAX_CYCLES_PER_INSTR = 5;

  // Bit numbers inside the F register
  localparam int FLAG_Z = 7;
  localparam int FLAG_N = 6;
  localparam int FLAG_H = 5;
  localparam int FLAG_C = 4;

  typedef struct packed {
    logic [7:0]  a;
    logic [7:0]  flags;
    logic [7:0]  b;
    logic [7:0]  c;
    logic [7:0]  d;
    logic [7:0]  e;
    logic [7:0]  h;
    logic [7:0]  l;
    logic [15:0] pc;
    logic [15:0] sp;
    logic [7:0]  z;  // Operand latch, low byte
    logic [7:0]  w;  // Operand latch, high byte
  } cpu_regs_t;

  typedef enum logic [1:0] {T1, T2, T3, T4} t_phase_t;

  typedef enum logic [2:0] {ADDR_PC, ADDR_SP, ADDR_HL, ADDR_WZ, ADDR_NONE} addr_src_t;

  typedef enum logic [1:0] {
    DATA_BUS_OP_READ,
    DATA_BUS_OP_WRITE,
    DATA_BUS_OP_ALU_ONLY
  } data_bus_op_t;

  typedef enum logic [3:0] {
    REG_A, REG_B, REG_C, REG_D, REG_E, REG_H, REG_L, REG_Z, REG_W, REG_NONE
  } reg_sel_t;

  typedef enum logic [1:0] {IDU_NONE, IDU_INC, IDU_DEC} idu_op_t;

  typedef enum logic [3:0] {
    ALU_NONE, ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR, ALU_OR, ALU_INC, ALU_DEC, ALU_MOV
  } alu_op_t;

  typedef enum logic [1:0] {MISC_NONE, MISC_COND_CHECK, MISC_JUMP_WZ, MISC_HALT} misc_op_t;

  typedef enum logic [1:0] {COND_NZ, COND_Z, COND_NC, COND_C} cond_t;

  typedef struct packed {
    addr_src_t    addr_src;
    data_bus_op_t data_bus_op;
    reg_sel_t     data_bus_src;  // Source on writes, destination on reads
    idu_op_t      idu_op;
    alu_op_t      alu_op;
    reg_sel_t     alu_dst;
    reg_sel_t     alu_src;
    misc_op_t     misc_op;
    cond_t        cond;
  } cycle_word_t;

  typedef struct packed {
    logic [2:0] num_cycles;
    cycle_word_t [MAX_CYCLES_PER_INSTR-1:0] cycles;
  } control_word_t;

  typedef logic [2:0] cycle_count_t;

  // Slot that holds the opcode fetch of every instruction
  localparam cycle_count_t FINAL_SLOT = cycle_count_t'(MAX_CYCLES_PER_INSTR - 1);

  localparam cycle_word_t IDLE_CYCLE = '{
    addr_src: ADDR_NONE, data_bus_op: DATA_BUS_OP_ALU_ONLY, data_bus_src: REG_NONE,
    idu_op: IDU_NONE, alu_op: ALU_NONE, alu_dst: REG_NONE, alu_src: REG_NONE,
    misc_op: MISC_NONE, cond: COND_NZ
  };

  localparam cycle_word_t FETCH_CYCLE = '{
    addr_src: ADDR_PC, data_bus_op: DATA_BUS_OP_READ, data_bus_src: REG_NONE,
    idu_op: IDU_INC, alu_op: ALU_NONE, alu_dst: REG_NONE, alu_src: REG_NONE,
    misc_op: MISC_NONE, cond: COND_NZ
  };

  localparam cycle_word_t HALT_CYCLE = '{
    addr_src: ADDR_NONE, data_bus_op: DATA_BUS_OP_ALU_ONLY, data_bus_src: REG_NONE,
    idu_op: IDU_NONE, alu_op: ALU_NONE, alu_dst: REG_NONE, alu_src: REG_NONE,
    misc_op: MISC_HALT, cond: COND_NZ
  };

  function automatic logic [7:0] get_reg(cpu_regs_t regs, reg_sel_t sel);
    case (sel)
      REG_A:   return regs.a;
      REG_B:   return regs.b;
      REG_C:   return regs.c;
      REG_D:   return regs.d;
      REG_E:   return regs.e;
      REG_H:   return regs.h;
      REG_L:   return regs.l;
      REG_Z:   return regs.z;
      REG_W:   return regs.w;
      default: return 8'h00;
    endcase
  endfunction

  function automatic cpu_regs_t set_reg(cpu_regs_t regs, reg_sel_t sel, logic [7:0] val);
    case (sel)
      REG_A:   regs.a = val;
      REG_B:   regs.b = val;
      REG_C:   regs.c = val;
      REG_D:   regs.d = val;
      REG_E:   regs.e = val;
      REG_H:   regs.h = val;
      REG_L:   regs.l = val;
      REG_Z:   regs.z = val;
      REG_W:   regs.w = val;
      default: ;  // REG_NONE leaves the file untouched
    endcase
    return regs;
  endfunction

endpackage

`default_nettype wire

// ==== logic/gb_soc.sv ====
`timescale 1ns/1ps
`default_nettype none

module gb_soc #(
  parameter int ADDR_WIDTH = 16
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        load_en,
  input  logic [15:0] load_addr,
  input  logic [7:0]  load_data,
  output logic [15:0] bus_addr,
  output logic        bus_write,
  output logic [7:0]  bus_wdata,
  output logic        halted
);

  wire [15:0] addr_bus;
  wire [7:0]  data_bus;      // Shared tristate bus
  wire        mmu_req_read;
  wire        mmu_req_write;

  cpu_core u_core (
    .clk           (clk),
    .reset         (reset),
    .addr_bus      (addr_bus),
    .data_bus      (data_bus),
    .mmu_req_read  (mmu_req_read),
    .mmu_req_write (mmu_req_write),
    .halted        (halted)
  );

  mmu #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_mmu (
    .clk           (clk),
    .reset         (reset),
    .addr_bus      (addr_bus),
    .data_bus      (data_bus),
    .mmu_req_read  (mmu_req_read),
    .mmu_req_write (mmu_req_write),
    .load_en       (load_en),
    .load_addr     (load_addr),
    .load_data     (load_data)
  );

  // Observation of CPU writes
  assign bus_addr  = addr_bus;
  assign bus_write = mmu_req_write;
  assign bus_wdata = data_bus;

endmodule

`default_nettype wire

// ==== logic/mmu.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmu #(
  parameter int ADDR_WIDTH = 16
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [15:0] addr_bus,
  inout  wire  [7:0]  data_bus,
  input  logic        mmu_req_read,
  input  logic        mmu_req_write,
  input  logic        load_en,
  input  logic [15:0] load_addr,
  input  logic [7:0]  load_data
);

  logic [7:0]            mem [2**ADDR_WIDTH];
  logic [ADDR_WIDTH-1:0] bus_idx;   // Upper address bits fold onto the array
  logic [ADDR_WIDTH-1:0] load_idx;

  assign bus_idx  = addr_bus[ADDR_WIDTH-1:0];
  assign load_idx = load_addr[ADDR_WIDTH-1:0];

  // Answers within the same phase, no wait states
  assign data_bus = mmu_req_read ? mem[bus_idx] : 'z;

  always_ff @(posedge clk) begin
    if (reset) begin
      if (load_en) mem[load_idx] <= load_data;  // Program load only while held in reset
    end else if (mmu_req_write) begin
      mem[bus_idx] <= data_bus;
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module gb_soc_tb \
  -f gb_soc.f -Mdir obj_dir -o gb_soc_sim

# Keep running past assertion errors so the testbench can print its summary
./obj_dir/gb_soc_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  echo "run_sim: passed"
  exit 0
else
  echo "run_sim: failed"
  exit 1
fi
